/* rtl/aes_types_pkg.sv */
////////////////////
// Shared AES-128 data types and field constants for the round datapath.
// Imported by every stage that handles state bytes or GF(2^8) arithmetic.
////////////////////
`default_nettype none

package aes_types_pkg;

    localparam int NUM_BYTES = 16;                          // Bytes in one AES state.

    typedef logic [7:0] aes_byte_t;                         // One state byte.
    typedef logic [3:0] byte_index_t;                       // Byte position 0..15.

    // Column-major state, byte 0 sits in bits 7:0.
    typedef aes_byte_t [NUM_BYTES-1:0] aes_state_t;

    localparam byte_index_t LAST_INDEX = byte_index_t'(NUM_BYTES - 1);  // Final byte position.
    localparam aes_byte_t AES_REDUCE   = 8'h1b;             // x^8 reduced by the AES polynomial.
    localparam aes_byte_t AES_AFFINE_C = 8'h63;             // S-box affine constant.

    // Multiply by x in GF(2^8).
    function automatic aes_byte_t aes_xtime(aes_byte_t b);
        aes_byte_t shifted;
        shifted = {b[6:0], 1'b0};                           // Plain shift left.
        if (b[7])
        begin
            shifted = shifted ^ AES_REDUCE;                 // Fold the overflow bit back in.
        end
        return shifted;
    endfunction

endpackage

`default_nettype wire

/* rtl/aes_ctrl_pkg.sv */
////////////////////
// State encodings for the small control FSMs of the round stages.
// Used by the substitution and collector stages.
////////////////////
`default_nettype none

package aes_ctrl_pkg;

    // Request FSM inside the substitution stage.
    typedef enum logic
    {
        IDLE  = 1'b0,                                       // Waiting for a fresh state.
        FETCH = 1'b1                                        // Issuing read requests.
    } fetch_state_e;

    // Fill tracking inside the collector.
    typedef enum logic
    {
        EMPTY   = 1'b0,                                     // No byte of a round seen yet.
        FILLING = 1'b1                                      // Part of a state written.
    } collect_state_e;

endpackage

`default_nettype wire

/* rtl/byte_stream_if.sv */
////////////////////
// Byte-serial link between round stages.
// The dst side raises req; the src side answers with one byte a cycle later.
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

    import aes_types_pkg::*;

    logic      req;                                         // Read request from the consumer.
    aes_byte_t data;                                        // Byte payload.
    logic      valid;                                       // Data holds a byte this cycle.
    logic      last;                                        // Marks byte 15 of the state.

    // Producer side.
    modport src (input req, output data, output valid, output last);

    // Consumer side.
    modport dst (output req, input data, input valid, input last);

endinterface

`default_nettype wire

/* rtl/add_round_key.sv */
////////////////////
// First stage of the round: XOR of state and round key.
// Accepts start only while the datapath is idle and pulses load once.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module add_round_key (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,                // Round request.
    input  logic                      final_round,          // Skip MixColumns for this round.
    input  aes_types_pkg::aes_state_t state_in,
    input  aes_types_pkg::aes_state_t round_key,
    input  logic                      busy,                 // A round is in flight.
    output logic                      load,                 // One-cycle strobe to the serializer.
    output aes_types_pkg::aes_state_t ark_state,
    output logic                      ark_final
);

    logic accept;

    assign accept = start & ~busy;                          // Starts during a round are dropped.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            load      <= 1'b0;
            ark_state <= '0;
            ark_final <= 1'b0;
        end
        else
        begin
            load <= accept;                                 // High for exactly one cycle.
            if (accept)
            begin
                ark_state <= state_in ^ round_key;          // AddRoundKey.
                ark_final <= final_round;                   // Held for the whole round.
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/state_serializer.sv */
////////////////////
// Sixteen-byte holding register read out one byte per request.
// Each req returns the next byte, in index order, on the following cycle.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module state_serializer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      load,                 // Store a new state.
    input  aes_types_pkg::aes_state_t load_state,
    byte_stream_if.src                bus
);

    import aes_types_pkg::*;

    aes_state_t  mem;                                       // Stored state bytes.
    byte_index_t rd_cnt;                                    // Next byte to hand out.
    byte_index_t rd_sel;                                    // Byte on the bus this cycle.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            mem <= '0;
        end
        else if (load)
        begin
            mem <= load_state;                              // Whole state in one cycle.
        end
    end

    // Read side follows the request by one cycle.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rd_cnt    <= '0;
            rd_sel    <= '0;
            bus.valid <= 1'b0;
            bus.last  <= 1'b0;
        end
        else
        begin
            bus.valid <= bus.req;
            bus.last  <= bus.req && (rd_cnt == LAST_INDEX);
            if (bus.req)
            begin
                rd_sel <= rd_cnt;                           // Delayed copy selects the data.
                if (rd_cnt == LAST_INDEX)
                    rd_cnt <= '0;                           // All 16 bytes read.
                else
                    rd_cnt <= rd_cnt + byte_index_t'(1);
            end
        end
    end

    assign bus.data = mem[rd_sel];

    // A read must never race a state load.
    req_not_during_load: assert property (
        @(posedge clk) disable iff (!resetn)
        !(bus.req && load)
    ) else $error("serializer read request in the load cycle");

endmodule

`default_nettype wire

/* rtl/byte_substitution.sv */
////////////////////
// SubBytes stage: pulls 16 bytes from the serializer and maps each through
// a computed S-box (GF(2^8) inverse then affine map), one byte per cycle.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module byte_substitution (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start_fetch,                         // Serializer was just loaded.
    byte_stream_if.dst in_bus,
    byte_stream_if.src out_bus
);

    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;

    fetch_state_e state;
    byte_index_t  req_cnt;                                  // Requests issued so far.

    // Shift-and-add multiply in GF(2^8).
    function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t p;
        acc = '0;
        p   = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ p;
            p = aes_xtime(p);
        end
        return acc;
    endfunction

    // x^254 is the inverse; zero maps to zero.
    function automatic aes_byte_t gf_inv(aes_byte_t x);
        aes_byte_t sq;
        aes_byte_t acc;
        sq  = x;
        acc = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);                           // x^(2^i).
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic aes_byte_t sbox(aes_byte_t x);
        aes_byte_t v;
        v = gf_inv(x);
        return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]}
                 ^ {v[3:0], v[7:4]} ^ AES_AFFINE_C;         // Affine transform.
    endfunction

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state   <= IDLE;
            req_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (start_fetch)
                    begin
                        state   <= FETCH;
                        req_cnt <= '0;
                    end
                FETCH:
                begin
                    req_cnt <= req_cnt + byte_index_t'(1);
                    if (req_cnt == LAST_INDEX)
                        state <= IDLE;                      // Sixteen requests sent.
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign in_bus.req = (state == FETCH);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            out_bus.valid <= 1'b0;
            out_bus.last  <= 1'b0;
        end
        else
        begin
            out_bus.valid <= in_bus.valid;
            out_bus.last  <= in_bus.valid && in_bus.last;
        end
    end

    // Payload byte, only meaningful with valid.
    always_ff @(posedge clk)
    begin
        if (in_bus.valid)
            out_bus.data <= sbox(in_bus.data);
    end

    // A new state may only arrive once the previous fetch is over.
    no_start_in_fetch: assert property (
        @(posedge clk) disable iff (!resetn)
        start_fetch |-> (state != FETCH)
    ) else $error("substitution stage restarted during a fetch");

endmodule

`default_nettype wire

/* rtl/state_collector.sv */
////////////////////
// Reassembles the substituted byte stream into a full 16-byte state.
// Pulses full on the cycle after the byte marked last.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module state_collector (
    input  logic                      clk,
    input  logic                      resetn,
    byte_stream_if.dst                bus,
    output logic                      full,                 // One-cycle completion strobe.
    output aes_types_pkg::aes_state_t collected
);

    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;

    collect_state_e state;
    byte_index_t    wr_idx;                                 // Next byte position to fill.

    assign bus.req = 1'b0;                                  // Upstream pushes without requests.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= EMPTY;
            wr_idx    <= '0;
            full      <= 1'b0;
            collected <= '0;
        end
        else
        begin
            full <= (state == FILLING) && bus.valid && bus.last;
            if (bus.valid)
            begin
                collected[wr_idx] <= bus.data;
                if (bus.last)
                    wr_idx <= '0;                           // Ready for the next round.
                else
                    wr_idx <= wr_idx + byte_index_t'(1);
            end
            case (state)
                EMPTY:
                    if (bus.valid)
                        state <= FILLING;                   // First byte of a round.
                FILLING:
                    if (bus.valid && bus.last)
                        state <= EMPTY;
                default:
                    state <= EMPTY;
            endcase
        end
    end

    // Last has to land on byte 15, otherwise the counters drifted apart.
    last_at_index_15: assert property (
        @(posedge clk) disable iff (!resetn)
        (bus.valid && bus.last) |-> (wr_idx == LAST_INDEX)
    ) else $error("collector saw last away from byte 15");

endmodule

`default_nettype wire

/* rtl/mix_stage.sv */
////////////////////
// Output stage: ShiftRows and, outside the final round, MixColumns.
// Registers the result and pulses done; the result holds until the next done.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mix_stage (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      full,                 // Collected state is complete.
    input  logic                      final_round,
    input  aes_types_pkg::aes_state_t in_state,
    output logic                      done,
    output aes_types_pkg::aes_state_t out_state
);

    import aes_types_pkg::*;

    aes_state_t shifted;

    // Row r rotates left by r columns; byte index is 4*col + row.
    function automatic aes_state_t shift_rows(aes_state_t s);
        aes_state_t r;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                r[4*c + row] = s[4*((c + row) % 4) + row];
        end
        return r;
    endfunction

    function automatic aes_state_t mix_columns(aes_state_t s);
        aes_state_t r;
        aes_byte_t  a0;
        aes_byte_t  a1;
        aes_byte_t  a2;
        aes_byte_t  a3;
        for (int c = 0; c < 4; c++)
        begin
            a0 = s[4*c];
            a1 = s[4*c + 1];
            a2 = s[4*c + 2];
            a3 = s[4*c + 3];
            r[4*c]     = aes_xtime(a0) ^ aes_xtime(a1) ^ a1 ^ a2 ^ a3;   // 2 3 1 1.
            r[4*c + 1] = a0 ^ aes_xtime(a1) ^ aes_xtime(a2) ^ a2 ^ a3;   // 1 2 3 1.
            r[4*c + 2] = a0 ^ a1 ^ aes_xtime(a2) ^ aes_xtime(a3) ^ a3;   // 1 1 2 3.
            r[4*c + 3] = aes_xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_xtime(a3);   // 3 1 1 2.
        end
        return r;
    endfunction

    assign shifted = shift_rows(in_state);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            done      <= 1'b0;
            out_state <= '0;
        end
        else
        begin
            done <= full;
            if (full)
                out_state <= final_round ? shifted : mix_columns(shifted);
        end
    end

endmodule

`default_nettype wire

/* rtl/aes_round.sv */
////////////////////
// AES-128 round datapath top: AddRoundKey, byte-serial SubBytes, ShiftRows
// and MixColumns. One round per start; done follows 21 cycles later.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_round (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,
    input  logic                      final_round,
    input  aes_types_pkg::aes_state_t state_in,
    input  aes_types_pkg::aes_state_t round_key,
    output aes_types_pkg::aes_state_t state_out,
    output logic                      done,
    output logic                      busy
);

    import aes_types_pkg::*;

    logic       load;                                       // Serializer write strobe.
    logic       ark_final;                                  // Final flag travelling with the round.
    logic       full;                                       // Collector completion strobe.
    logic       busy_q;                                     // Round in flight after the load cycle.
    aes_state_t ark_state;
    aes_state_t collected;

    byte_stream_if ser_bus ();                              // Serializer to S-box stage.
    byte_stream_if sub_bus ();                              // S-box stage to collector.

    add_round_key add_round_key_inst (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .final_round (final_round),
        .state_in    (state_in),
        .round_key   (round_key),
        .busy        (busy),
        .load        (load),
        .ark_state   (ark_state),
        .ark_final   (ark_final)
    );

    state_serializer state_serializer_inst (
        .clk        (clk),
        .resetn     (resetn),
        .load       (load),
        .load_state (ark_state),
        .bus        (ser_bus)
    );

    byte_substitution byte_substitution_inst (
        .clk         (clk),
        .resetn      (resetn),
        .start_fetch (load),
        .in_bus      (ser_bus),
        .out_bus     (sub_bus)
    );

    state_collector state_collector_inst (
        .clk       (clk),
        .resetn    (resetn),
        .bus       (sub_bus),
        .full      (full),
        .collected (collected)
    );

    mix_stage mix_stage_inst (
        .clk         (clk),
        .resetn      (resetn),
        .full        (full),
        .final_round (ark_final),
        .in_state    (collected),
        .done        (done),
        .out_state   (state_out)
    );

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            busy_q <= 1'b0;
        else if (load)
            busy_q <= 1'b1;                                 // Set behind the load strobe.
        else if (done)
            busy_q <= 1'b0;                                 // Cleared once the result is out.
    end

    assign busy = load | busy_q;                            // Covers cycles 1 through 21.

endmodule

`default_nettype wire

/* test/tb_aes_round.sv */
////////////////////
// Testbench for the AES-128 round datapath.
// Random rounds from an LFSR are checked against a behavioral round model,
// together with latency, busy, ignored starts, reset state and a FIPS-197 vector.
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_aes_round;

    import aes_types_pkg::*;

    localparam int CLK_PERIOD   = 10;                       // ns.
    localparam int RESET_CYCLES = 10;
    localparam int LATENCY      = 21;                       // Start to done, in cycles.
    localparam int DONE_LIMIT   = 40;                       // Give up waiting for done here.
    localparam int N_FULL       = 200;                      // Rounds with MixColumns.
    localparam int N_FINAL      = 20;                       // Rounds without MixColumns.
    localparam int N_BUSY       = 20;                       // Rounds with a second start.
    localparam int QUIET_CYCLES = 24;                       // Watch for stray done pulses.
    localparam int ROUND_CYCLES = 30;
    localparam int TOTAL_ROUNDS = N_FULL + N_FINAL + 2 * N_BUSY + 1;
    localparam int WATCH_CYCLES = ROUND_CYCLES * TOTAL_ROUNDS + 2 * RESET_CYCLES;

    logic        clk;
    logic        resetn;
    logic        start;
    logic        final_round;
    aes_state_t  state_in;
    aes_state_t  round_key;
    aes_state_t  state_out;
    logic        done;
    logic        busy;
    logic [31:0] lfsr_state;                                // Random source.

    aes_round aes_round_inst (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .final_round (final_round),
        .state_in    (state_in),
        .round_key   (round_key),
        .state_out   (state_out),
        .done        (done),
        .busy        (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Ends every failing path.
    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_state(input string name, input aes_state_t got, input aes_state_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_byte(input string name, input aes_byte_t got, input aes_byte_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    // Right-shift Galois LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h80200003;
        return n;
    endfunction

    task automatic random_bits(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);             // One step per bit.
            v[i] = lfsr_state[0];
        end
    endtask

    task automatic random_state(output aes_state_t s);
        logic [127:0] v;
        random_bits(128, v);
        s = v;
    endtask

    // Full polynomial product, then reduction by x^8+x^4+x^3+x+1.
    function automatic aes_byte_t gf_mult(input aes_byte_t a, input aes_byte_t b);
        logic [14:0] prod;
        prod = '0;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                prod = prod ^ (15'(a) << i);
        end
        for (int i = 14; i >= 8; i--)
        begin
            if (prod[i])
                prod = prod ^ (15'h11b << (i - 8));
        end
        return prod[7:0];
    endfunction

    // Inverse by search; zero stays zero.
    function automatic aes_byte_t model_inverse(input aes_byte_t x);
        aes_byte_t y;
        y = 8'h01;
        if (x == 8'h00)
            return 8'h00;
        while (gf_mult(x, y) != 8'h01)
            y = y + 8'h01;
        return y;
    endfunction

    function automatic aes_byte_t model_sbox(input aes_byte_t x);
        aes_byte_t inv;
        aes_byte_t s;
        inv = model_inverse(x);
        for (int i = 0; i < 8; i++)                         // FIPS-197 affine map, bit by bit.
            s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                 ^ inv[(i + 7) % 8] ^ AES_AFFINE_C[i];
        return s;
    endfunction

    // AddRoundKey, SubBytes, ShiftRows, then MixColumns unless final.
    function automatic aes_state_t model_round(input aes_state_t st, input aes_state_t key,
                                               input logic fin);
        aes_state_t a;
        aes_state_t b;
        aes_state_t r;
        aes_byte_t  coef [4];
        aes_byte_t  acc;
        coef = '{8'h02, 8'h03, 8'h01, 8'h01};               // First row of the MixColumns matrix.
        a = st ^ key;
        for (int i = 0; i < NUM_BYTES; i++)
            a[i] = model_sbox(a[i]);
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                b[4*((c + 4 - row) % 4) + row] = a[4*c + row];  // Moves row columns left.
        end
        if (fin)
            return b;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                acc = 8'h00;
                for (int k = 0; k < 4; k++)
                    acc = acc ^ gf_mult(coef[(k - row + 4) % 4], b[4*c + k]);
                r[4*c + row] = acc;
            end
        end
        return r;
    endfunction

    // FIPS-197 listings give byte 0 first.
    function automatic aes_state_t fips_order(input logic [127:0] hex);
        aes_state_t s;
        for (int i = 0; i < NUM_BYTES; i++)
            s[i] = hex[127 - 8*i -: 8];
        return s;
    endfunction

    // Called on a falling edge. A nonzero extra_at adds a second start in that cycle.
    task automatic run_round(input aes_state_t st, input aes_state_t key, input logic fin,
                             input int extra_at, input aes_state_t extra_st,
                             input aes_state_t extra_key, output aes_state_t expected);
        int   cycle;
        logic seen;
        expected = model_round(st, key, fin);
        seen     = 1'b0;
        check_bit("busy", busy, 1'b0);                      // Idle before the start.
        start       = 1'b1;                                 // Cycle 0.
        final_round = fin;
        state_in    = st;
        round_key   = key;
        @(negedge clk);
        cycle = 1;
        while (!seen)
        begin
            if (cycle == extra_at)
            begin
                start       = 1'b1;                         // Dropped while busy is high.
                final_round = ~fin;
                state_in    = extra_st;
                round_key   = extra_key;
            end
            else
            begin
                start = 1'b0;
            end
            check_bit("busy", busy, 1'b1);
            if (done === 1'b1)
            begin
                seen = 1'b1;
            end
            else if (cycle >= DONE_LIMIT)
            begin
                $display("done did not pulse within %0d cycles after start", DONE_LIMIT);
                fail_run();
            end
            else
            begin
                @(negedge clk);
                cycle++;
            end
        end
        check_latency("done latency", cycle, LATENCY);
        check_state("state_out", state_out, expected);
        @(negedge clk);
        start = 1'b0;
        check_bit("done", done, 1'b0);                      // One-cycle pulse.
        check_bit("busy", busy, 1'b0);
        check_state("state_out", state_out, expected);
    endtask

    // No done and a steady result while idle.
    task automatic check_quiet(input int cycles, input aes_state_t held);
        repeat (cycles)
        begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
            check_state("state_out", state_out, held);
        end
    endtask

    initial
    begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("watchdog: the run took longer than %0d cycles and was stopped", WATCH_CYCLES);
        fail_run();
    end

    initial
    begin
        aes_state_t   st;
        aes_state_t   key;
        aes_state_t   st2;
        aes_state_t   key2;
        aes_state_t   result;
        logic [127:0] pick;
        clk         = 1'b0;
        resetn      = 1'b0;
        start       = 1'b0;
        final_round = 1'b0;
        state_in    = '0;
        round_key   = '0;
        lfsr_state  = 32'h0a831946;

        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_state("state_out", state_out, '0);

        // Model S-box against published values.
        check_byte("model sbox 00", model_sbox(8'h00), 8'h63);
        check_byte("model sbox 01", model_sbox(8'h01), 8'h7c);
        check_byte("model sbox 53", model_sbox(8'h53), 8'hed);
        check_byte("model sbox ff", model_sbox(8'hff), 8'h16);

        // FIPS-197 appendix B, first round up to MixColumns.
        st  = fips_order(128'h3243f6a8885a308d313198a2e0370734);
        key = fips_order(128'h2b7e151628aed2a6abf7158809cf4f3c);
        check_state("model fips round", model_round(st, key, 1'b0),
                    fips_order(128'h046681e5e0cb199a48f8d37a2806264c));
        run_round(st, key, 1'b0, 0, st, key, result);
        check_state("fips state_out", state_out,
                    fips_order(128'h046681e5e0cb199a48f8d37a2806264c));

        for (int n = 0; n < N_FULL; n++)
        begin
            random_state(st);
            random_state(key);
            run_round(st, key, 1'b0, 0, st, key, result);
        end

        for (int n = 0; n < N_FINAL; n++)
        begin
            random_state(st);
            random_state(key);
            run_round(st, key, 1'b1, 0, st, key, result);
        end

        for (int n = 0; n < N_BUSY; n++)
        begin
            random_state(st);
            random_state(key);
            random_state(st2);
            random_state(key2);
            random_bits(6, pick);
            run_round(st, key, pick[5], (pick[4:0] % LATENCY) + 1, st2, key2, result);
            check_quiet(QUIET_CYCLES, result);              // Second start left no trace.
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* aes_round.f */
rtl/aes_types_pkg.sv
rtl/aes_ctrl_pkg.sv
rtl/byte_stream_if.sv
rtl/add_round_key.sv
rtl/state_serializer.sv
rtl/byte_substitution.sv
rtl/state_collector.sv
rtl/mix_stage.sv
rtl/aes_round.sv
test/tb_aes_round.sv
